/* include/videoPixel_config.svh */
// Video pixel generator configuration
`ifndef VIDEO_PIXEL_CONFIG_SVH
`define VIDEO_PIXEL_CONFIG_SVH

// Display counter widths
// 11 bits reach full HD
`define H_WIDTH 11
`define V_WIDTH 11

// FIFO depths per stage
`define DOT_FIFO_DEPTH 16
`define PIXEL_FIFO_DEPTH 16

// Square side growth per frame
// Must stay well below the display width
`define SCENE_STEP 2

`endif

/* src/videoPixelPkg.sv */
// Video pixel types
`include "videoPixel_config.svh"

package videoPixelPkg;

	//--------------------------------------------------------------------
	// Display coordinates and sizes
	//--------------------------------------------------------------------
	typedef logic [`H_WIDTH-1:0] hPos_t;
	typedef logic [`V_WIDTH-1:0] vPos_t;

	//--------------------------------------------------------------------
	// Colour formats, 4 bits per channel
	//--------------------------------------------------------------------
	// Layer dot with alpha in the top nibble
	typedef struct packed {
		logic [3:0] alpha;
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} argbDot_t;

	// Final display pixel, alpha removed
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgbPixel_t;

endpackage

/* src/pixelDrawPosition.sv */
// Raster position counter
`timescale 1ns/100ps

module pixelDrawPosition (
	input  logic                iClk,
	input  logic                rstN,
	input  videoPixelPkg::hPos_t hDisplay,
	input  videoPixelPkg::vPos_t vDisplay,
	input  logic                advance,
	output videoPixelPkg::hPos_t hPos,
	output videoPixelPkg::vPos_t vPos,
	output logic                posValid,
	output logic                frameEnd
);
	import videoPixelPkg::*;

	// Last column and row, registered against wire delay
	hPos_t hMax;
	vPos_t vMax;
	hPos_t hCount;
	vPos_t vCount;
	// Limits are loaded one cycle after reset
	logic sizeReady;
	logic step;

	always_ff @(posedge iClk)
	begin
		hMax <= hDisplay - 1'b1;
		vMax <= vDisplay - 1'b1;
	end

	assign step = advance & sizeReady;

	//--------------------------------------------------------------------
	// Raster walk, row by row
	//--------------------------------------------------------------------
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			hCount    <= '0;
			vCount    <= '0;
			sizeReady <= 1'b0;
		end
		else
		begin
			sizeReady <= 1'b1;
			if (step)
			begin
				if (hCount == hMax)
				begin
					hCount <= '0;
					// Wrap to top after last row
					vCount <= (vCount == vMax) ? '0 : vCount + 1'b1;
				end
				else
					hCount <= hCount + 1'b1;
			end
		end
	end

	assign hPos     = hCount;
	assign vPos     = vCount;
	assign posValid = step;
	// Bottom-right dot closes the frame
	assign frameEnd = step && (hCount == hMax) && (vCount == vMax);

endmodule

/* src/syncFifo.sv */
// Synchronous FIFO with typed payload
`timescale 1ns/100ps

module syncFifo #(
	parameter type payload_t = logic [7:0],
	parameter int  depth     = 16
) (
	input  logic     iClk,
	input  logic     rstN,
	input  logic     writeEn,
	input  payload_t writeData,
	input  logic     readEn,
	output payload_t readData,
	output logic     readValid,
	output logic     empty,
	output logic     almostFull
);

	localparam int ptrWidth   = (depth > 1) ? $clog2(depth) : 1;
	localparam int countWidth = $clog2(depth + 1);

	payload_t              mem [depth];
	logic [ptrWidth-1:0]   wrPtr;
	logic [ptrWidth-1:0]   rdPtr;
	// Occupancy, 0 to depth
	logic [countWidth-1:0] count;

	//--------------------------------------------------------------------
	// Storage and read port
	//--------------------------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (writeEn)
			mem[wrPtr] <= writeData;
		// Data lands one cycle after the read enable
		if (readEn)
			readData <= mem[rdPtr];
	end

	//--------------------------------------------------------------------
	// Pointers and occupancy
	//--------------------------------------------------------------------
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			count     <= '0;
			readValid <= 1'b0;
		end
		else
		begin
			readValid <= readEn;
			if (writeEn)
				wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;
			if (readEn)
				rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
			// Simultaneous write and read leaves count alone
			if (writeEn && !readEn)
				count <= count + 1'b1;
			else if (readEn && !writeEn)
				count <= count - 1'b1;
		end
	end

	assign empty      = (count == '0);
	// Two or fewer free slots, room for producer pipeline
	assign almostFull = (count >= countWidth'(depth - 2));

endmodule

/* src/sceneChange.sv */
// Growing square scene layer
`timescale 1ns/100ps
`include "videoPixel_config.svh"

module sceneChange (
	input  logic                   iClk,
	input  logic                   rstN,
	input  videoPixelPkg::hPos_t    hDisplay,
	input  videoPixelPkg::argbDot_t sceneColor,
	input  videoPixelPkg::hPos_t    hPos,
	input  videoPixelPkg::vPos_t    vPos,
	input  logic                   posValid,
	input  logic                   frameEnd,
	output logic                   almostFull,
	output logic                   dotFifoEmpty,
	input  logic                   dotReadEn,
	output videoPixelPkg::argbDot_t dot,
	output logic                   dotValid
);
	import videoPixelPkg::*;

	// Square side in force for the current frame
	hPos_t             side;
	// One extra bit so the sum cannot wrap
	logic [`H_WIDTH:0] sideNext;
	logic              inSquare;
	argbDot_t          dotReg;
	logic              dotWrite;

	//--------------------------------------------------------------------
	// Per-frame animation, one step per frame
	//--------------------------------------------------------------------
	assign sideNext = {1'b0, side} + (`H_WIDTH + 1)'(`SCENE_STEP);

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
			side <= '0;
		else if (frameEnd)
			// Back to empty once wider than the display
			side <= (sideNext > {1'b0, hDisplay}) ? '0 : sideNext[`H_WIDTH-1:0];
	end

	//--------------------------------------------------------------------
	// Dot selection
	//--------------------------------------------------------------------
	// Top-left anchored square
	assign inSquare = (hPos < side) && (vPos < side);

	// Dot payload register
	always_ff @(posedge iClk)
	begin
		if (posValid)
			dotReg <= inSquare ? sceneColor : '0;
	end

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
			dotWrite <= 1'b0;
		else
			dotWrite <= posValid;
	end

	// Layer output buffer
	syncFifo #(
		.payload_t (argbDot_t),
		.depth     (`DOT_FIFO_DEPTH)
	) dotFifo (
		.iClk       (iClk),
		.rstN       (rstN),
		.writeEn    (dotWrite),
		.writeData  (dotReg),
		.readEn     (dotReadEn),
		.readData   (dot),
		.readValid  (dotValid),
		.empty      (dotFifoEmpty),
		.almostFull (almostFull)
	);

endmodule

/* src/dotMergeToPixel.sv */
// Dot to pixel alpha merge
`timescale 1ns/100ps
`include "videoPixel_config.svh"

module dotMergeToPixel (
	input  logic                    iClk,
	input  logic                    rstN,
	input  videoPixelPkg::rgbPixel_t backColor,
	input  videoPixelPkg::argbDot_t  dot,
	input  logic                    dotValid,
	input  logic                    pixelReadEn,
	output videoPixelPkg::rgbPixel_t pixel,
	output logic                    pixelValid,
	output logic                    pixelFifoEmpty,
	output logic                    pixelAlmostFull
);
	import videoPixelPkg::*;

	rgbPixel_t blended;
	rgbPixel_t pixelReg;
	logic      pixelWrite;

	// One channel of the blend, nibble result
	function automatic logic [3:0] blendChannel(
		input logic [3:0] alpha,
		input logic [3:0] front,
		input logic [3:0] back
	);
		logic [7:0] mix;
		// Weights sum to 16, max 240 fits 8 bits
		mix = alpha * front + (8'd16 - alpha) * back;
		if (alpha == 4'd15)
			blendChannel = front;
		else if (alpha == 4'd0)
			blendChannel = back;
		else
			blendChannel = mix[7:4];
	endfunction

	//--------------------------------------------------------------------
	// Blend stage, one register
	//--------------------------------------------------------------------
	always_comb
	begin
		blended.red   = blendChannel(dot.alpha, dot.red, backColor.red);
		blended.green = blendChannel(dot.alpha, dot.green, backColor.green);
		blended.blue  = blendChannel(dot.alpha, dot.blue, backColor.blue);
	end

	always_ff @(posedge iClk)
	begin
		if (dotValid)
			pixelReg <= blended;
	end

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
			pixelWrite <= 1'b0;
		else
			pixelWrite <= dotValid;
	end

	// Output buffer towards display
	syncFifo #(
		.payload_t (rgbPixel_t),
		.depth     (`PIXEL_FIFO_DEPTH)
	) pixelFifo (
		.iClk       (iClk),
		.rstN       (rstN),
		.writeEn    (pixelWrite),
		.writeData  (pixelReg),
		.readEn     (pixelReadEn),
		.readData   (pixel),
		.readValid  (pixelValid),
		.empty      (pixelFifoEmpty),
		.almostFull (pixelAlmostFull)
	);

endmodule

/* src/videoPixelGen.sv */
// Video pixel generator top
`timescale 1ns/100ps

module videoPixelGen (
	input  logic                    iClk,
	input  logic                    rstN,
	input  videoPixelPkg::hPos_t     hDisplay,
	input  videoPixelPkg::vPos_t     vDisplay,
	input  videoPixelPkg::argbDot_t  sceneColor,
	input  videoPixelPkg::rgbPixel_t backColor,
	input  logic                    displayCke,
	output videoPixelPkg::rgbPixel_t pixel,
	output logic                    pixelValid
);
	import videoPixelPkg::*;

	// Raster position stream
	hPos_t    hPos;
	vPos_t    vPos;
	logic     posValid;
	logic     frameEnd;
	logic     advance;
	// Scene layer side
	logic     dotAlmostFull;
	logic     dotFifoEmpty;
	logic     dotReadEn;
	argbDot_t dot;
	logic     dotValid;
	// Merge side
	logic     pixelReadEn;
	logic     pixelFifoEmpty;
	logic     pixelAlmostFull;

	//--------------------------------------------------------------------
	// Flow control between stages
	//--------------------------------------------------------------------
	// Counter holds once the dot FIFO nears full
	assign advance     = ~dotAlmostFull;
	// Merge pulls dots while the pixel FIFO has room
	assign dotReadEn   = ~dotFifoEmpty & ~pixelAlmostFull;
	// Display drains with its clock enable
	assign pixelReadEn = displayCke & ~pixelFifoEmpty;

	//--------------------------------------------------------------------
	// Stage instances
	//--------------------------------------------------------------------
	pixelDrawPosition positionCounter (
		.iClk     (iClk),
		.rstN     (rstN),
		.hDisplay (hDisplay),
		.vDisplay (vDisplay),
		.advance  (advance),
		.hPos     (hPos),
		.vPos     (vPos),
		.posValid (posValid),
		.frameEnd (frameEnd)
	);

	sceneChange sceneLayer (
		.iClk         (iClk),
		.rstN         (rstN),
		.hDisplay     (hDisplay),
		.sceneColor   (sceneColor),
		.hPos         (hPos),
		.vPos         (vPos),
		.posValid     (posValid),
		.frameEnd     (frameEnd),
		.almostFull   (dotAlmostFull),
		.dotFifoEmpty (dotFifoEmpty),
		.dotReadEn    (dotReadEn),
		.dot          (dot),
		.dotValid     (dotValid)
	);

	dotMergeToPixel mergeStage (
		.iClk            (iClk),
		.rstN            (rstN),
		.backColor       (backColor),
		.dot             (dot),
		.dotValid        (dotValid),
		.pixelReadEn     (pixelReadEn),
		.pixel           (pixel),
		.pixelValid      (pixelValid),
		.pixelFifoEmpty  (pixelFifoEmpty),
		.pixelAlmostFull (pixelAlmostFull)
	);

endmodule

/* tb/videoPixelGen_asserts.sv */
// Pixel generator protocol checks
`timescale 1ns/100ps
`include "videoPixel_config.svh"

module videoPixelGenAsserts (
	input logic                                      iClk,
	input logic                                      rstN,
	input videoPixelPkg::hPos_t                      hDisplay,
	input videoPixelPkg::hPos_t                      hPos,
	input logic                                      pixelValid,
	input logic                                      dotWrite,
	input logic [$clog2(`DOT_FIFO_DEPTH + 1)-1:0]    dotCount,
	input logic                                      dotReadEn,
	input logic                                      pixelWrite,
	input logic [$clog2(`PIXEL_FIFO_DEPTH + 1)-1:0]  pixelCount,
	input logic                                      pixelReadEn
);

	// Failure counts per property
	int writeFails = 0;
	int readFails  = 0;
	int rangeFails = 0;
	int resetFails = 0;

	// Occupancy tracked from the enables alone
	logic [$clog2(`DOT_FIFO_DEPTH + 1)-1:0]   dotLevel;
	logic [$clog2(`PIXEL_FIFO_DEPTH + 1)-1:0] pixelLevel;

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			dotLevel   <= '0;
			pixelLevel <= '0;
		end
		else
		begin
			if (dotWrite && !dotReadEn)
				dotLevel <= dotLevel + 1'b1;
			else if (dotReadEn && !dotWrite)
				dotLevel <= dotLevel - 1'b1;
			if (pixelWrite && !pixelReadEn)
				pixelLevel <= pixelLevel + 1'b1;
			else if (pixelReadEn && !pixelWrite)
				pixelLevel <= pixelLevel - 1'b1;
		end
	end

	//--------------------------------------------------------------------
	// FIFO protocol
	//--------------------------------------------------------------------
	// No write into a full FIFO
	assert property (@(posedge iClk) disable iff (!rstN)
		!((dotWrite && dotCount == `DOT_FIFO_DEPTH)
			|| (pixelWrite && pixelCount == `PIXEL_FIFO_DEPTH)))
	else
	begin
		$error("FIFO written while full");
		writeFails++;
	end

	// No read from an empty FIFO
	assert property (@(posedge iClk) disable iff (!rstN)
		!((dotReadEn && dotLevel == '0) || (pixelReadEn && pixelLevel == '0)))
	else
	begin
		$error("FIFO read while empty");
		readFails++;
	end

	//--------------------------------------------------------------------
	// Raster and reset behaviour
	//--------------------------------------------------------------------
	// Column inside the display
	assert property (@(posedge iClk) disable iff (!rstN) hPos < hDisplay)
	else
	begin
		$error("column counter reached the display width");
		rangeFails++;
	end

	assert property (@(posedge iClk) !rstN |-> !pixelValid)
	else
	begin
		$error("pixelValid high during reset");
		resetFails++;
	end

endmodule

/* tb/videoPixelGenTb.sv */
// Video pixel generator testbench
`timescale 1ns/100ps
`include "videoPixel_config.svh"

module videoPixelGenTb;
	import videoPixelPkg::*;

	localparam int clkPeriod   = 40;
	localparam int resetCycles = 8;
	// Longest gap allowed between two pixels
	localparam int pixelWait   = 64;
	// Pixels checked over all tests
	localparam int totalPixels = 3 * 48 + 9 * 48 + 4 * 48 + 6 * 24;

	logic      iClk;
	logic      rstN;
	hPos_t     hDisplay;
	vPos_t     vDisplay;
	argbDot_t  sceneColor;
	rgbPixel_t backColor;
	logic      displayCke;
	rgbPixel_t pixel;
	logic      pixelValid;

	int mismatchCount;
	int otherCount;
	int seed;

	videoPixelGen dut0 (
		.iClk       (iClk),
		.rstN       (rstN),
		.hDisplay   (hDisplay),
		.vDisplay   (vDisplay),
		.sceneColor (sceneColor),
		.backColor  (backColor),
		.displayCke (displayCke),
		.pixel      (pixel),
		.pixelValid (pixelValid)
	);

	// Protocol checker inside the top level
	bind videoPixelGen videoPixelGenAsserts checker0 (
		.iClk           (iClk),
		.rstN           (rstN),
		.hDisplay       (hDisplay),
		.hPos           (hPos),
		.pixelValid     (pixelValid),
		.dotWrite       (sceneLayer.dotWrite),
		.dotCount       (sceneLayer.dotFifo.count),
		.dotReadEn      (dotReadEn),
		.pixelWrite     (mergeStage.pixelWrite),
		.pixelCount     (mergeStage.pixelFifo.count),
		.pixelReadEn    (pixelReadEn)
	);

	initial
	begin
		iClk = 1'b0;
		forever
			#(clkPeriod / 2) iClk = ~iClk;
	end

	//--------------------------------------------------------------------
	// Reference model
	//--------------------------------------------------------------------
	// Blend one nibble, scene over back
	function automatic logic [3:0] blendNibble(input int alpha, input int front, input int back);
		int mixed;
		if (alpha == 15)
			mixed = front;
		else if (alpha == 0)
			mixed = back;
		else
			mixed = (alpha * front + (16 - alpha) * back) >> 4;
		return mixed[3:0];
	endfunction

	function automatic rgbPixel_t expectedPixel(input int h, input int v, input int side,
		input argbDot_t scene, input rgbPixel_t back);
		argbDot_t  layerDot;
		rgbPixel_t result;
		// Transparent outside the square
		layerDot     = (h < side && v < side) ? scene : '0;
		result.red   = blendNibble(int'(layerDot.alpha), int'(layerDot.red), int'(back.red));
		result.green = blendNibble(int'(layerDot.alpha), int'(layerDot.green), int'(back.green));
		result.blue  = blendNibble(int'(layerDot.alpha), int'(layerDot.blue), int'(back.blue));
		return result;
	endfunction

	// Square side for the following frame
	function automatic int nextSide(input int side, input int hSize);
		int grown;
		grown = side + `SCENE_STEP;
		return (grown > hSize) ? 0 : grown;
	endfunction

	//--------------------------------------------------------------------
	// Stimulus helpers
	//--------------------------------------------------------------------
	// Called on a rising edge, releases on the 8th edge
	task automatic applyReset(input string testName);
		int cycle;
		rstN <= 1'b0;
		for (cycle = 0; cycle < resetCycles; cycle++)
		begin
			@(posedge iClk);
			assert (!pixelValid)
			else
			begin
				otherCount++;
				$display("%s: pixelValid high during reset", testName);
			end
		end
		rstN <= 1'b1;
	endtask

	// Wait for the next pixel, driving displayCke each edge
	// cke 1 holds it high, 2 gives random stalls
	task automatic waitPixel(input string testName, input int cke, output bit seen);
		int cycle;
		int rnd;
		seen = 1'b0;
		for (cycle = 0; cycle < pixelWait && !seen; cycle++)
		begin
			@(posedge iClk);
			seen = pixelValid;
			if (dut0.posValid)
			begin
				assert (dut0.vPos < vDisplay)
				else
				begin
					otherCount++;
					$display("%s: row %0d produced beyond display height", testName, dut0.vPos);
				end
			end
			rnd = $random(seed);
			displayCke <= (cke == 2) ? rnd[0] : (cke == 1);
		end
	endtask

	//--------------------------------------------------------------------
	// Directed tests
	//--------------------------------------------------------------------
	task automatic checkResetQuiet();
		int cycle;
		@(posedge iClk);
		hDisplay   <= hPos_t'(8);
		vDisplay   <= vPos_t'(6);
		displayCke <= 1'b0;
		applyReset("reset");
		// Display never reads, so nothing may appear
		for (cycle = 0; cycle < 24; cycle++)
		begin
			@(posedge iClk);
			assert (!pixelValid)
			else
			begin
				otherCount++;
				$display("reset: pixelValid high while displayCke is low");
			end
		end
	endtask

	// Check whole frames against the model from reset on
	task automatic runFrames(input string testName, input int hSize, input int vSize,
		input argbDot_t scene, input rgbPixel_t back, input int frames, input int cke);
		int        frame;
		int        v;
		int        h;
		int        side;
		bit        seen;
		rgbPixel_t expected;
		@(posedge iClk);
		hDisplay   <= hPos_t'(hSize);
		vDisplay   <= vPos_t'(vSize);
		sceneColor <= scene;
		backColor  <= back;
		displayCke <= 1'b0;
		applyReset(testName);
		side = 0;
		for (frame = 0; frame < frames; frame++)
		begin
			for (v = 0; v < vSize; v++)
			begin
				for (h = 0; h < hSize; h++)
				begin
					waitPixel(testName, cke, seen);
					if (!seen)
					begin
						otherCount++;
						$display("%s: no pixel for frame %0d row %0d column %0d", testName,
							frame, v, h);
						return;
					end
					expected = expectedPixel(h, v, side, scene, back);
					assert (pixel == expected)
					else
					begin
						mismatchCount++;
						$display("Mismatch %s frame %0d (%0d,%0d): expected %h, actual %h",
							testName, frame, h, v, expected, pixel);
					end
				end
			end
			side = nextSide(side, hSize);
		end
	endtask

	// Watchdog over the whole run
	initial
	begin
		#(totalPixels * 8 * clkPeriod);
		$display("Timeout: tests did not finish within %0d cycles", totalPixels * 8);
		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
		$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		seed          = 32'hce11_9ac7;
		mismatchCount = 0;
		otherCount    = 0;
		rstN          = 1'b0;
		hDisplay      = hPos_t'(8);
		vDisplay      = vPos_t'(6);
		sceneColor    = '0;
		backColor     = '0;
		displayCke    = 1'b0;

		checkResetQuiet();
		runFrames("opaque square", 8, 6, 16'hf5a3, 12'h124, 3, 1);
		// Same half-transparent colour over several backgrounds
		runFrames("partial alpha dark", 8, 6, 16'h6c3a, 12'h000, 3, 1);
		runFrames("partial alpha light", 8, 6, 16'h6c3a, 12'hfff, 3, 1);
		runFrames("partial alpha mixed", 8, 6, 16'h6c3a, 12'h5a9, 3, 1);
		runFrames("back-pressure", 8, 6, 16'h97e2, 12'h3c6, 4, 2);
		// Side runs 0, 2, 4, 6, then back to 0
		runFrames("side wrap", 6, 4, 16'hf0f0, 12'h00f, 6, 1);

		otherCount += dut0.checker0.writeFails + dut0.checker0.readFails
			+ dut0.checker0.rangeFails + dut0.checker0.resetFails;
		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
		if (mismatchCount == 0 && otherCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* tb.f */
+incdir+include
src/videoPixelPkg.sv
src/pixelDrawPosition.sv
src/syncFifo.sv
src/sceneChange.sv
src/dotMergeToPixel.sv
src/videoPixelGen.sv
tb/videoPixelGen_asserts.sv
tb/videoPixelGenTb.sv

/* Makefile */
# Verilator build and run for the video pixel generator

VERILATOR ?= verilator
TOP       ?= videoPixelGenTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
